// ==== source/organ_pkg.sv ====
package organ_pkg;

  // ====================
  // Widths and types
  // ====================

  // Switch code of a note, C5 up to C6
  typedef logic [2:0] note_sel_t;

  // Clock cycles in half a tone period
  typedef logic [15:0] half_period_t;

  // Signed sample for the audio path
  typedef logic signed [7:0] audio_sample_t;

  // Signed offset on the sampling count
  typedef logic signed [15:0] speed_t;

  // Scope sampling count shown on the digits
  typedef logic [15:0] sample_count_t;

  // Active-low segments, bit 0 is segment a
  typedef logic [6:0] seg_t;

  // Raw active-low keys
  // Bit 0 faster, bit 1 slower, bit 2 clear
  typedef logic [2:0] key_bus_t;

  // Conditioned key events
  // Faster and slower are single-cycle pulses, clear is a level
  typedef struct packed {
    logic clear;
    logic slower;
    logic faster;
  } key_events_t;

  // ====================
  // Constants
  // ====================

  // Half periods at 50 MHz, C5 to C6
  localparam half_period_t NOTE_HALF_PERIOD [8] = '{
    16'd47801,
    16'd42590,
    16'd37936,
    16'd35817,
    16'd31888,
    16'd28409,
    16'd25310,
    16'd23900
  };

  // Square wave levels
  localparam audio_sample_t AUDIO_HIGH = 8'h7F;
  localparam audio_sample_t AUDIO_LOW  = 8'h80;

  // Tick periods in clock cycles
  localparam int LED_TICK_DEFAULT     = 25_000_000;
  localparam int KEY_TICK_DEFAULT     = 50_000;
  localparam int DISPLAY_TICK_DEFAULT = 12_500_000;

  // Key ticks between two repeats of a held key
  localparam int REPEAT_TICKS = 100;

  // Speed control
  localparam speed_t        SPEED_STEP           = 16'sd100;
  localparam sample_count_t DEFAULT_SAMPLE_COUNT = 16'd12499;

  // Seven-segment digits on the board
  localparam int DIGITS = 6;

endpackage

// ==== source/tone_generator.sv ====
`timescale 1ns/1ps

module tone_generator (
  input  logic                     CLK_50M,
  input  logic                     rst_n,
  input  organ_pkg::note_sel_t     note,
  input  logic                     sound_enable,
  output organ_pkg::audio_sample_t audio_sample
);

  import organ_pkg::*;

  half_period_t half_period;
  half_period_t period_q;
  half_period_t cycle_cnt;
  logic         wave;
  logic         wrap;

  // ====================
  // Note lookup
  // ====================

  // Half period of the note on the switches
  assign half_period = NOTE_HALF_PERIOD[note];

  // Last cycle of the current level
  assign wrap = (cycle_cnt == period_q - 1'b1);

  // ====================
  // Square wave
  // ====================

  // Counter runs 0 to period_q - 1, then wraps
  // New note only loaded on a wrap
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      cycle_cnt <= '0;
      period_q  <= half_period;
      wave      <= 1'b0;
    end
    else if (wrap)
    begin
      cycle_cnt <= '0;
      period_q  <= half_period;
      wave      <= ~wave;
    end
    else
    begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  // Gated signed sample, one cycle behind the wave
  // Zero while sound is off
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      audio_sample <= '0;
    else if (!sound_enable)
      audio_sample <= '0;
    else
      audio_sample <= wave ? AUDIO_HIGH : AUDIO_LOW;
  end

  // Counter stays below the latched half period across note changes
  assert property (@(posedge CLK_50M) disable iff (!rst_n) cycle_cnt < period_q)
    else $error("tone_generator: count %0h past half period %0h", cycle_cnt, period_q);

endmodule

// ==== source/led_chaser.sv ====
`timescale 1ns/1ps

module led_chaser #(
  parameter int TICK_CYCLES = organ_pkg::LED_TICK_DEFAULT
) (
  input  logic       CLK_50M,
  input  logic       rst_n,
  output logic [7:0] leds
);

  localparam int CNT_W = $clog2(TICK_CYCLES + 1);

  logic [CNT_W-1:0] tick_cnt;
  logic             led_tick;

  // ====================
  // LED tick
  // ====================

  // One pulse every TICK_CYCLES clocks
  assign led_tick = (tick_cnt == CNT_W'(TICK_CYCLES - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      tick_cnt <= '0;
    else if (led_tick)
      tick_cnt <= '0;
    else
      tick_cnt <= tick_cnt + 1'b1;
  end

  // ====================
  // Chaser
  // ====================

  // Lit LED walks left, bit 7 wraps to bit 0
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      leds <= 8'h01;
    else if (led_tick)
      leds <= {leds[6:0], leds[7]};
  end

  // Exactly one LED lit at all times
  assert property (@(posedge CLK_50M) disable iff (!rst_n) $onehot(leds))
    else $error("led_chaser: pattern %0h not one-hot", leds);

endmodule

// ==== source/key_conditioner.sv ====
`timescale 1ns/1ps

module key_conditioner #(
  parameter int TICK_CYCLES = organ_pkg::KEY_TICK_DEFAULT
) (
  input  logic                   CLK_50M,
  input  logic                   rst_n,
  input  organ_pkg::key_bus_t    keys,
  output organ_pkg::key_events_t events
);

  import organ_pkg::*;

  localparam int TICK_W = $clog2(TICK_CYCLES + 1);
  localparam int REP_W  = $clog2(REPEAT_TICKS + 1);

  key_bus_t          keys_meta;
  key_bus_t          keys_sync;
  logic [TICK_W-1:0] tick_cnt;
  logic              key_tick;
  logic [REP_W-1:0]  rep_cnt;
  logic              repeat_fire;
  logic              faster_q;
  logic              slower_q;

  // ====================
  // Synchronizers
  // ====================

  // Keys inverted so a pressed key reads 1
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      keys_meta <= '0;
      keys_sync <= '0;
    end
    else
    begin
      keys_meta <= ~keys;
      keys_sync <= keys_meta;
    end
  end

  // ====================
  // Repeat limiter
  // ====================

  // Key tick, 1 kHz at the default period
  assign key_tick = (tick_cnt == TICK_W'(TICK_CYCLES - 1));

  // Fires once every REPEAT_TICKS key ticks
  assign repeat_fire = key_tick && (rep_cnt == REP_W'(REPEAT_TICKS - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      tick_cnt <= '0;
      rep_cnt  <= '0;
    end
    else if (key_tick)
    begin
      tick_cnt <= '0;
      rep_cnt  <= repeat_fire ? '0 : rep_cnt + 1'b1;
    end
    else
    begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  // Held key gives one pulse per firing
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      faster_q <= 1'b0;
      slower_q <= 1'b0;
    end
    else
    begin
      faster_q <= repeat_fire & keys_sync[0];
      slower_q <= repeat_fire & keys_sync[1];
    end
  end

  // Clear passes straight from the synchronizer
  assign events = '{clear: keys_sync[2], slower: slower_q, faster: faster_q};

  // Speed pulses never last past one cycle
  assert property (@(posedge CLK_50M) disable iff (!rst_n)
                   (events.faster || events.slower) |=> !(events.faster || events.slower))
    else $error("key_conditioner: speed pulse held for two cycles");

endmodule

// ==== source/speed_register.sv ====
`timescale 1ns/1ps

module speed_register (
  input  logic                     CLK_50M,
  input  logic                     rst_n,
  input  organ_pkg::key_events_t   events,
  output organ_pkg::sample_count_t sample_count
);

  import organ_pkg::*;

  speed_t speed;

  // ====================
  // Speed value
  // ====================

  // Clear wins over both pulses
  // Steps of SPEED_STEP, two's complement
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      speed <= '0;
    end
    else if (events.clear)
    begin
      speed <= '0;
    end
    else if (events.faster)
    begin
      speed <= speed + SPEED_STEP;
    end
    else if (events.slower)
    begin
      speed <= speed - SPEED_STEP;
    end
  end

  // ====================
  // Sampling count
  // ====================

  // Default count plus signed offset
  // Sum wraps modulo 2^16
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      sample_count <= DEFAULT_SAMPLE_COUNT;
    else
      sample_count <= DEFAULT_SAMPLE_COUNT + sample_count_t'(speed);
  end

endmodule

// ==== source/hex_display.sv ====
`timescale 1ns/1ps

module hex_display #(
  parameter int TICK_CYCLES = organ_pkg::DISPLAY_TICK_DEFAULT
) (
  input  logic                     CLK_50M,
  input  logic                     rst_n,
  input  organ_pkg::sample_count_t sample_count,
  output organ_pkg::seg_t          hex [organ_pkg::DIGITS]
);

  import organ_pkg::*;

  localparam int CNT_W   = $clog2(TICK_CYCLES + 1);
  localparam int SHOWN_W = 4 * DIGITS;

  logic [CNT_W-1:0]   tick_cnt;
  logic               disp_tick;
  logic [SHOWN_W-1:0] shown;

  // Hex nibble to active-low segments, gfedcba
  function automatic seg_t seg_decode(input logic [3:0] nibble);
    seg_t seg;
    case (nibble)
      4'h0: seg = 7'h40;
      4'h1: seg = 7'h79;
      4'h2: seg = 7'h24;
      4'h3: seg = 7'h30;
      4'h4: seg = 7'h19;
      4'h5: seg = 7'h12;
      4'h6: seg = 7'h02;
      4'h7: seg = 7'h78;
      4'h8: seg = 7'h00;
      4'h9: seg = 7'h10;
      4'hA: seg = 7'h08;
      4'hB: seg = 7'h03;
      4'hC: seg = 7'h46;
      4'hD: seg = 7'h21;
      4'hE: seg = 7'h06;
      default: seg = 7'h0E;
    endcase
    return seg;
  endfunction

  // ====================
  // Display latch
  // ====================

  assign disp_tick = (tick_cnt == CNT_W'(TICK_CYCLES - 1));

  // Count zero-extended to all six digits
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      tick_cnt <= '0;
      shown    <= '0;
    end
    else if (disp_tick)
    begin
      tick_cnt <= '0;
      shown    <= SHOWN_W'(sample_count);
    end
    else
    begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  // Digit 0 carries the low nibble
  for (genvar i = 0; i < DIGITS; i++)
  begin : g_digit
    assign hex[i] = seg_decode(shown[4*i +: 4]);
  end

endmodule

// ==== source/basic_organ_top.sv ====
`timescale 1ns/1ps

module basic_organ_top #(
  parameter int LED_TICK     = organ_pkg::LED_TICK_DEFAULT,
  parameter int KEY_TICK     = organ_pkg::KEY_TICK_DEFAULT,
  parameter int DISPLAY_TICK = organ_pkg::DISPLAY_TICK_DEFAULT
) (
  input  logic                     CLK_50M,
  input  logic                     rst_n,
  input  logic [9:0]               switches,
  input  organ_pkg::key_bus_t      keys,
  output organ_pkg::audio_sample_t audio_sample,
  output logic [7:0]               leds,
  output organ_pkg::seg_t          hex [organ_pkg::DIGITS]
);

  import organ_pkg::*;

  key_events_t   key_events;
  sample_count_t sample_count;

  // ====================
  // Tone path
  // ====================

  // Note on SW[3:1], sound enable on SW[0]
  tone_generator u_tone (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .note         (switches[3:1]),
    .sound_enable (switches[0]),
    .audio_sample (audio_sample)
  );

  led_chaser #(.TICK_CYCLES(LED_TICK)) u_leds (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .leds    (leds)
  );

  // ====================
  // Speed control
  // ====================

  key_conditioner #(.TICK_CYCLES(KEY_TICK)) u_keys (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .keys    (keys),
    .events  (key_events)
  );

  speed_register u_speed (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .events       (key_events),
    .sample_count (sample_count)
  );

  // Count shown in hex on the six digits
  hex_display #(.TICK_CYCLES(DISPLAY_TICK)) u_hex (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .sample_count (sample_count),
    .hex          (hex)
  );

endmodule

// ==== bench/tb_basic_organ.sv ====
`timescale 1ns/1ps

module tb_basic_organ;

  // Short tick periods for simulation
  localparam int LED_TICK     = 40;
  localparam int KEY_TICK     = 5;
  localparam int DISPLAY_TICK = 30;
  localparam int REPEAT_TICKS = 100;
  localparam int TONE_LIMIT   = 100_000;
  localparam int KEY_LIMIT    = REPEAT_TICKS * KEY_TICK + 2 * DISPLAY_TICK + 20;
  localparam int CLEAR_LIMIT  = 2 * DISPLAY_TICK + 10;

  typedef enum logic [1:0] {ACT_NONE, ACT_FASTER, ACT_SLOWER, ACT_CLEAR} key_action_t;

  // One row of stimulus and its expected value
  typedef struct packed {
    logic [2:0]  note;
    logic        enable;
    key_action_t action;
    logic [23:0] expected;
  } stim_row_t;

  logic        CLK_50M = 1'b0;
  logic        rst_n;
  logic [9:0]  switches;
  logic [2:0]  keys;
  logic [7:0]  audio_sample;
  logic [7:0]  leds;
  logic [6:0]  hex [6];

  int          errors = 0;
  int          checks = 0;
  int          led_steps = 0;
  logic [7:0]  leds_prev;
  logic [7:0]  leds_exp;
  logic [31:0] lfsr_state = 32'h83fc_3095;
  stim_row_t   table_q [$];

  // Half periods of C5 to C6 in clock cycles
  logic [15:0] half_ref [8] = '{16'd47801, 16'd42590, 16'd37936, 16'd35817,
                                16'd31888, 16'd28409, 16'd25310, 16'd23900};

  // Active-low segments gfedcba for 0 to F
  logic [6:0] seg_ref [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                               7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};

  basic_organ_top #(
    .LED_TICK     (LED_TICK),
    .KEY_TICK     (KEY_TICK),
    .DISPLAY_TICK (DISPLAY_TICK)
  ) dut (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .switches     (switches),
    .keys         (keys),
    .audio_sample (audio_sample),
    .leds         (leds),
    .hex          (hex)
  );

  // 50 MHz clock
  always #10 CLK_50M = ~CLK_50M;

  // ====================
  // Helpers
  // ====================

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step for each of three bits
  function automatic logic [2:0] random_note();
    logic [2:0] n;
    for (int b = 0; b < 3; b++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      n[b] = lfsr_state[0];
    end
    return n;
  endfunction

  // Unknown pattern decodes to x so any compare fails
  function automatic logic [23:0] decode_display();
    logic [23:0] value;
    value = 'x;
    for (int d = 0; d < 6; d++)
      for (int v = 0; v < 16; v++)
        if (hex[d] === seg_ref[v])
          value[4*d +: 4] = v[3:0];
    return value;
  endfunction

  function automatic void add_row(input logic [2:0] note, input logic en,
                                  input key_action_t act, input logic [23:0] exp);
    table_q.push_back('{note, en, act, exp});
  endfunction

  // Inputs change on the rising edge only
  task automatic drive_inputs(input logic [2:0] note, input logic en, input logic [2:0] k);
    @(posedge CLK_50M);
    switches <= {6'b0, note, en};
    keys     <= k;
  endtask

  task automatic check_value(input string name, input logic [23:0] got,
                             input logic [23:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("[FAIL] %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // Falling edges until audio_sample changes
  task automatic wait_audio_change(output int cycles);
    logic [7:0] prev;
    logic       seen;
    prev   = audio_sample;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < TONE_LIMIT)
    begin
      @(negedge CLK_50M);
      cycles++;
      if (audio_sample !== prev)
        seen = 1'b1;
    end
    if (!seen)
    begin
      $display("Timeout: audio_sample did not toggle within %0d cycles", TONE_LIMIT);
      errors++;
    end
    else if (audio_sample !== 8'h7F && audio_sample !== 8'h80)
    begin
      $display("[FAIL] audio_sample: got %h expected 7f or 80", audio_sample);
      errors++;
    end
  endtask

  // ====================
  // Row handlers
  // ====================

  // Two toggles skipped so the new note is loaded
  task automatic check_tone(input logic [2:0] note, input logic [23:0] exp);
    int cycles;
    drive_inputs(note, 1'b1, 3'b111);
    wait_audio_change(cycles);
    wait_audio_change(cycles);
    wait_audio_change(cycles);
    check_value("audio_sample half period", 24'(cycles), exp);
  endtask

  task automatic check_silence(input logic [2:0] note, input int span);
    int n;
    drive_inputs(note, 1'b0, 3'b111);
    repeat (2) @(negedge CLK_50M);
    n = 0;
    while (n < span && audio_sample === 8'h00)
    begin
      @(negedge CLK_50M);
      n++;
    end
    check_value("audio_sample while disabled", 24'(audio_sample), 24'h0);
  endtask

  // Hold a speed key until the digits move
  task automatic press_speed_key(input int idx, input logic [23:0] exp);
    logic [23:0] prev;
    logic [2:0]  k;
    int          n;
    prev   = decode_display();
    k      = 3'b111;
    k[idx] = 1'b0;
    drive_inputs(3'd0, 1'b0, k);
    n = 0;
    while (decode_display() === prev && n < KEY_LIMIT)
    begin
      @(negedge CLK_50M);
      n++;
    end
    if (decode_display() === prev)
    begin
      $display("Timeout: display count did not change while key %0d held", idx);
      errors++;
    end
    drive_inputs(3'd0, 1'b0, 3'b111);
    check_value("hex count", decode_display(), exp);
  endtask

  task automatic hold_clear(input logic [23:0] exp);
    int n;
    drive_inputs(3'd0, 1'b0, 3'b011);
    n = 0;
    while (decode_display() !== exp && n < CLEAR_LIMIT)
    begin
      @(negedge CLK_50M);
      n++;
    end
    drive_inputs(3'd0, 1'b0, 3'b111);
    check_value("hex count after clear", decode_display(), exp);
  endtask

  // Watch the LED pattern for one-hot and left rotation from 8'h01
  always @(negedge CLK_50M)
  begin
    if (rst_n === 1'b1)
    begin
      if (!$onehot(leds))
      begin
        $display("[FAIL] leds: got %h expected one-hot", leds);
        errors++;
      end
      if (leds !== leds_prev)
      begin
        led_steps++;
        leds_exp = 8'h01 << (led_steps % 8);
        if (leds !== leds_exp)
        begin
          $display("[FAIL] leds: got %h expected %h", leds, leds_exp);
          errors++;
        end
      end
    end
    leds_prev <= leds;
  end

  // ====================
  // Main sequence
  // ====================

  initial
  begin
    logic [2:0] n;
    rst_n    = 1'b0;
    switches = '0;
    keys     = 3'b111;

    // Every note followed by silence and the speed keys
    for (int i = 0; i < 8; i++)
      add_row(3'(i), 1'b1, ACT_NONE, 24'(half_ref[i]));
    add_row(3'd5, 1'b0, ACT_NONE, 24'(half_ref[5]));
    add_row(3'd0, 1'b0, ACT_FASTER, 24'd12599);
    add_row(3'd0, 1'b0, ACT_FASTER, 24'd12699);
    add_row(3'd0, 1'b0, ACT_SLOWER, 24'd12599);
    add_row(3'd0, 1'b0, ACT_CLEAR, 24'd12499);
    add_row(3'd0, 1'b0, ACT_SLOWER, 24'd12399);
    add_row(3'd0, 1'b0, ACT_CLEAR, 24'd12499);
    for (int i = 0; i < 2; i++)
    begin
      n = random_note();
      add_row(n, 1'b1, ACT_NONE, 24'(half_ref[n]));
    end

    repeat (3) @(posedge CLK_50M);
    rst_n <= 1'b1;
    @(negedge CLK_50M);
    check_value("audio_sample after reset", 24'(audio_sample), 24'h0);
    check_value("leds after reset", 24'(leds), 24'h01);
    for (int d = 0; d < 6; d++)
      check_value("hex digit after reset", 24'(hex[d]), 24'h40);

    // First display tick shows the default count
    for (int c = 0; c < DISPLAY_TICK + 5 && decode_display() !== 24'h0030D3; c++)
      @(negedge CLK_50M);
    check_value("hex count after first tick", decode_display(), 24'h0030D3);

    foreach (table_q[i])
    begin
      case (table_q[i].action)
        ACT_FASTER: press_speed_key(0, table_q[i].expected);
        ACT_SLOWER: press_speed_key(1, table_q[i].expected);
        ACT_CLEAR:  hold_clear(table_q[i].expected);
        default:
        begin
          if (table_q[i].enable)
            check_tone(table_q[i].note, table_q[i].expected);
          else
            check_silence(table_q[i].note, int'(table_q[i].expected));
        end
      endcase
    end

    if (led_steps == 0)
    begin
      $display("LED pattern never moved during the run");
      errors++;
    end

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== project.f ====
source/organ_pkg.sv
source/tone_generator.sv
source/led_chaser.sv
source/key_conditioner.sv
source/speed_register.sv
source/hex_display.sv
source/basic_organ_top.sv
bench/tb_basic_organ.sv
